/* common/conv_cfg_pkg.sv */
/*
 * Geometry and width constants of the convolution row engine.
 * Banks are addressed in words, and all addresses wrap modulo BANK_DEPTH.
 * Legal tap counts are 1 to 32. ACC_W leaves headroom for 32 full-scale taps.
 */

package conv_cfg_pkg;

  // Bank array geometry.
  localparam int N_ROW      = 4;              // Rows of banks, one result per row.
  localparam int N_COL      = 4;              // Columns of banks, one activation per column.
  localparam int N_BANK     = N_ROW * N_COL;  // Total number of weight banks.
  localparam int BANK_IDX_W = 4;              // Width of a bank index on the preload port.

  // Word and address widths.
  localparam int WORD_W     = 16;             // Weight, bias and activation width.
  localparam int BANK_DEPTH = 64;             // Words held by each bank.
  localparam int ADDR_W     = 6;              // Word address width inside a bank.
  localparam int TAP_W      = 6;              // Width of the tap count field.

  // Accumulation and result widths.
  localparam int ACC_W      = 40;             // Internal accumulator width.
  localparam int RES_W      = 32;             // Saturated result width.

  // Saturation limits expressed at accumulator width.
  localparam logic signed [ACC_W-1:0] RES_MAX =
    {{(ACC_W-RES_W+1){1'b0}}, {(RES_W-1){1'b1}}};  // Largest signed 32-bit value.
  localparam logic signed [ACC_W-1:0] RES_MIN =
    {{(ACC_W-RES_W+1){1'b1}}, {(RES_W-1){1'b0}}};  // Smallest signed 32-bit value.

endpackage

/* common/conv_types_pkg.sv */
/*
 * Bus structures and the phase encoding of the convolution row engine.
 * The job command is sampled once on acceptance and may change afterwards.
 * phase_t is shared by the FSM, the tap counter, the loader and the accumulators.
 */

package conv_types_pkg;

  import conv_cfg_pkg::*;

  // One job as issued by the host over the req/ack handshake.
  typedef struct packed {
    logic [ADDR_W-1:0]                base_addr;  // First word of the tap window.
    logic [ADDR_W-1:0]                bias_pos;   // Bias word offset from base_addr.
    logic [TAP_W-1:0]                 n_taps;     // Number of taps, 1 to 32.
    logic signed [N_COL-1:0][WORD_W-1:0] act;     // One activation per column.
  } job_cmd_t;

  // One read request towards a single weight bank.
  typedef struct packed {
    logic              en;    // Read enable.
    logic [ADDR_W-1:0] addr;  // Word address.
  } bank_req_t;

  // One host preload write.
  typedef struct packed {
    logic                  valid;  // Write strobe.
    logic [BANK_IDX_W-1:0] bank;   // Target bank, row * N_COL + column.
    logic [ADDR_W-1:0]     addr;   // Word address inside the bank.
    logic [WORD_W-1:0]     data;   // Weight or bias word.
  } preload_t;

  // Saturated results, one per row.
  typedef struct packed {
    logic signed [N_ROW-1:0][RES_W-1:0] row;
  } row_result_t;

  // Job sequencing phases.
  typedef enum logic [2:0] {
    IDLE,      // Waiting for a request.
    BIAS,      // Column-0 banks read the bias word.
    BIAS_CAP,  // Biases are captured and loaded.
    TAPS,      // One tap read per cycle.
    DRAIN,     // Last products are accumulated.
    DONE       // Results valid and ack raised.
  } phase_t;

endpackage

/* weight_store/weight_bank.sv */
/*
 * Single-port weight bank with a synchronous write and a registered read.
 * Read data appears one cycle after an enabled request and holds otherwise.
 * A write and a read to the same word in one cycle returns the old word.
 */

`timescale 1ns/100ps

module weight_bank
  import conv_cfg_pkg::*, conv_types_pkg::*;
(
  input  logic              clk,        // Clock.
  input  logic              rst_n,      // Synchronous reset, active low.
  input  bank_req_t         rd_i,       // Read request from the loader.
  input  logic              wr_en_i,    // Host write enable for this bank.
  input  logic [ADDR_W-1:0] wr_addr_i,  // Host write address.
  input  logic [WORD_W-1:0] wr_data_i,  // Host write data.
  output logic [WORD_W-1:0] rdata_o     // Registered read data.
);

  logic [WORD_W-1:0] mem_q [BANK_DEPTH];  // Weight storage.

  // Host preload path.
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;  // Word written as given by the host.
    end
  end

  // Read port, updated only on an enabled request.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_o <= '0;                  // Clean output after reset.
    end else if (rd_i.en) begin
      rdata_o <= mem_q[rd_i.addr];    // Data valid in the next cycle.
    end
  end

endmodule

/* weight_store/weight_loader.sv */
/*
 * Weight loader with bias capture for the convolution row engine.
 * In BIAS only the column-0 bank of each row is read, at base plus bias position.
 * In TAPS every bank is read at the tap address given by the counter.
 * The biases are forwarded straight from the banks during BIAS_CAP.
 */

`timescale 1ns/100ps

module weight_loader
  import conv_cfg_pkg::*, conv_types_pkg::*;
(
  input  logic                           clk,           // Clock.
  input  logic                           rst_n,         // Synchronous reset, active low.
  input  phase_t                         phase_i,       // Current job phase.
  input  logic [ADDR_W-1:0]              base_addr_i,   // Job base address.
  input  logic [ADDR_W-1:0]              bias_pos_i,    // Bias offset from base.
  input  logic [ADDR_W-1:0]              tap_addr_i,    // Running tap address.
  output bank_req_t [N_BANK-1:0]         bank_req_o,    // One request per bank.
  input  logic [N_BANK-1:0][WORD_W-1:0]  bank_rdata_i,  // Read data of each bank.
  output logic [N_BANK-1:0][WORD_W-1:0]  weight_o,      // Weights to the accumulators.
  output logic [N_ROW-1:0][WORD_W-1:0]   bias_o         // One bias per row.
);

  logic [ADDR_W-1:0]            bias_addr;   // Word address of the bias.
  logic [N_ROW-1:0][WORD_W-1:0] bias_in;     // Column-0 read data per row.
  logic [N_ROW-1:0][WORD_W-1:0] bias_q;      // Captured biases.

  // Word addressing, so the offset is added without scaling.
  assign bias_addr = base_addr_i + bias_pos_i;  // Wraps modulo BANK_DEPTH.

  // Request routing for the bias and tap phases.
  always_comb begin
    for (int r = 0; r < N_ROW; r++) begin
      for (int c = 0; c < N_COL; c++) begin
        bank_req_o[r*N_COL+c].en   = 1'b0;       // Banks stay quiet by default.
        bank_req_o[r*N_COL+c].addr = tap_addr_i;
        if (phase_i == BIAS) begin
          bank_req_o[r*N_COL+c].en   = (c == 0);  // Biases live in column 0.
          bank_req_o[r*N_COL+c].addr = bias_addr;
        end else if (phase_i == TAPS) begin
          bank_req_o[r*N_COL+c].en   = 1'b1;      // Full array read per tap.
        end
      end
    end
  end

  // Column-0 read data of each row.
  always_comb begin
    for (int r = 0; r < N_ROW; r++) begin
      bias_in[r] = bank_rdata_i[r*N_COL];
    end
  end

  // Bias register, written once per job.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bias_q <= '0;
    end else if (phase_i == BIAS_CAP) begin
      bias_q <= bias_in;                 // Read issued in BIAS lands here.
    end
  end

  // The accumulators load in the same cycle the register captures.
  assign bias_o   = (phase_i == BIAS_CAP) ? bias_in : bias_q;

  // Tap weights go through unchanged.
  assign weight_o = bank_rdata_i;

endmodule

/* source/job_fsm.sv */
/*
 * Job sequencer with a four-phase req/ack handshake.
 * Latency from the accepting edge to ack high is n_taps + 4 cycles.
 * The host may raise req again only after ack is low. A tap count of zero is illegal.
 */

`timescale 1ns/100ps

module job_fsm
  import conv_types_pkg::*;
(
  input  logic     clk,         // Clock.
  input  logic     rst_n,       // Synchronous reset, active low.
  input  logic     req_i,       // Host request.
  input  job_cmd_t cmd_i,       // Host command, valid with req_i.
  input  logic     last_tap_i,  // Last tap read this cycle.
  output phase_t   phase_o,     // Current phase.
  output job_cmd_t cmd_o,       // Latched command.
  output logic     ack_o        // Host acknowledge.
);

  phase_t   state_q;   // Current phase.
  job_cmd_t cmd_q;     // Command held for the whole job.
  logic     accept;    // A new job is taken this cycle.

  // ack is always low in IDLE, so a request here is a fresh one.
  assign accept = (state_q == IDLE) && req_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      ack_o   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= BIAS;            // Bias read goes out next cycle.
          end
        end
        BIAS:     state_q <= BIAS_CAP;  // Bank answers one cycle later.
        BIAS_CAP: state_q <= TAPS;
        TAPS: begin
          if (last_tap_i) begin
            state_q <= DRAIN;           // Final products still to add.
          end
        end
        DRAIN:    state_q <= DONE;
        DONE: begin
          if (!ack_o) begin
            ack_o <= 1'b1;              // Results are registered on this edge.
          end else if (!req_i) begin
            ack_o   <= 1'b0;            // Host has released, close the handshake.
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Command capture on acceptance only.
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_i;                   // Host may change cmd_i after this.
    end
  end

  assign phase_o = state_q;
  assign cmd_o   = cmd_q;

endmodule

/* source/tap_counter.sv */
/*
 * Tap index counter. It clears outside TAPS and steps once per TAPS cycle.
 * The tap address wraps modulo the bank depth.
 */

`timescale 1ns/100ps

module tap_counter
  import conv_cfg_pkg::*, conv_types_pkg::*;
(
  input  logic              clk,          // Clock.
  input  logic              rst_n,        // Synchronous reset, active low.
  input  phase_t            phase_i,      // Current job phase.
  input  logic [ADDR_W-1:0] base_addr_i,  // Job base address.
  input  logic [TAP_W-1:0]  n_taps_i,     // Job tap count.
  output logic [ADDR_W-1:0] tap_addr_o,   // Bank address of the current tap.
  output logic              last_tap_o    // Current tap is the final one.
);

  logic [TAP_W-1:0] count_q;  // Taps already issued.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (phase_i == TAPS) begin
      count_q <= count_q + TAP_W'(1);  // One tap per cycle.
    end else begin
      count_q <= '0;                   // Ready for the next job.
    end
  end

  assign tap_addr_o = base_addr_i + count_q;  // Wraps past address 63.
  assign last_tap_o = (phase_i == TAPS) && (count_q == n_taps_i - TAP_W'(1));

endmodule

/* source/row_accumulator.sv */
/*
 * Multiply-accumulate for one row of banks.
 * Products of a tap read are added in the cycle after the read, tracked from the phase.
 * The result saturates to the signed 32-bit range and holds until the next job ends.
 */

`timescale 1ns/100ps

module row_accumulator
  import conv_cfg_pkg::*, conv_types_pkg::*;
(
  input  logic                          clk,       // Clock.
  input  logic                          rst_n,     // Synchronous reset, active low.
  input  phase_t                        phase_i,   // Current job phase.
  input  logic [WORD_W-1:0]             bias_i,    // Row bias.
  input  logic [N_COL-1:0][WORD_W-1:0]  weight_i,  // Weights of this row's banks.
  input  logic [N_COL-1:0][WORD_W-1:0]  act_i,     // Job activations.
  output logic signed [RES_W-1:0]       res_o      // Saturated row result.
);

  logic signed [2*WORD_W-1:0] prod [N_COL];  // Per-column products.
  logic signed [ACC_W-1:0]    tap_sum;       // Sum of one tap's products.
  logic signed [ACC_W-1:0]    acc_q;         // Running accumulator.
  logic signed [ACC_W-1:0]    sat;           // Accumulator clamped to 32 bits.
  logic                       tap_vld_q;     // Previous cycle issued a tap read.

  // Four signed products summed at full accumulator width.
  always_comb begin
    tap_sum = '0;
    for (int c = 0; c < N_COL; c++) begin
      prod[c] = $signed(weight_i[c]) * $signed(act_i[c]);
      tap_sum = tap_sum + prod[c];         // Sign-extended before the add.
    end
  end

  // Bank data lags the request by one cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tap_vld_q <= 1'b0;
    end else begin
      tap_vld_q <= (phase_i == TAPS);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (phase_i == BIAS_CAP) begin
      acc_q <= ACC_W'($signed(bias_i));    // Bias is the starting value.
    end else if (tap_vld_q) begin
      acc_q <= acc_q + tap_sum;            // Covers every TAPS cycle and DRAIN.
    end
  end

  // Clamp to the signed result range.
  always_comb begin
    if (acc_q > RES_MAX) begin
      sat = RES_MAX;
    end else if (acc_q < RES_MIN) begin
      sat = RES_MIN;
    end else begin
      sat = acc_q;
    end
  end

  // The accumulator is final in DONE, so the result is stable while ack is high.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_o <= '0;
    end else if (phase_i == DONE) begin
      res_o <= sat[RES_W-1:0];
    end
  end

endmodule

/* source/conv_engine_top.sv */
/*
 * Convolution row engine with sixteen preloaded weight banks.
 * Banks are preloaded through wr_i while no job is active. Writing during a job
 * is not allowed and is not arbitrated. One job is in flight at a time.
 */

`timescale 1ns/100ps

module conv_engine_top
  import conv_cfg_pkg::*, conv_types_pkg::*;
(
  input  logic        clk,     // Clock.
  input  logic        rst_n,   // Synchronous reset, active low.
  input  logic        req_i,   // Job request.
  input  job_cmd_t    cmd_i,   // Job command.
  output logic        ack_o,   // Job acknowledge.
  output row_result_t res_o,   // Row results, valid with ack_o.
  input  preload_t    wr_i     // Host bank preload.
);

  phase_t                       phase;       // Job phase from the FSM.
  job_cmd_t                     job_cmd;     // Latched command.
  logic [ADDR_W-1:0]            tap_addr;    // Running tap address.
  logic                         last_tap;    // Final tap flag.
  bank_req_t [N_BANK-1:0]       bank_req;    // Bank read requests.
  logic [N_BANK-1:0][WORD_W-1:0] bank_rdata; // Bank read data.
  logic [N_BANK-1:0][WORD_W-1:0] weight;     // Weights to the datapath.
  logic [N_ROW-1:0][WORD_W-1:0] bias;        // Row biases.

  job_fsm u_job_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .cmd_i      (cmd_i),
    .last_tap_i (last_tap),
    .phase_o    (phase),
    .cmd_o      (job_cmd),
    .ack_o      (ack_o)
  );

  tap_counter u_tap_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .phase_i     (phase),
    .base_addr_i (job_cmd.base_addr),
    .n_taps_i    (job_cmd.n_taps),
    .tap_addr_o  (tap_addr),
    .last_tap_o  (last_tap)
  );

  weight_loader u_weight_loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .phase_i      (phase),
    .base_addr_i  (job_cmd.base_addr),
    .bias_pos_i   (job_cmd.bias_pos),
    .tap_addr_i   (tap_addr),
    .bank_req_o   (bank_req),
    .bank_rdata_i (bank_rdata),
    .weight_o     (weight),
    .bias_o       (bias)
  );

  // Bank index is row * N_COL + column, as on the preload port.
  for (genvar b = 0; b < N_BANK; b++) begin : g_bank
    weight_bank u_weight_bank (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_i      (bank_req[b]),
      .wr_en_i   (wr_i.valid && (wr_i.bank == BANK_IDX_W'(b))),
      .wr_addr_i (wr_i.addr),
      .wr_data_i (wr_i.data),
      .rdata_o   (bank_rdata[b])
    );
  end

  for (genvar r = 0; r < N_ROW; r++) begin : g_row
    row_accumulator u_row_accumulator (
      .clk      (clk),
      .rst_n    (rst_n),
      .phase_i  (phase),
      .bias_i   (bias[r]),
      .weight_i (weight[r*N_COL +: N_COL]),
      .act_i    (job_cmd.act),
      .res_o    (res_o.row[r])
    );
  end

endmodule

/* test/conv_engine_tb.sv */
/*
 * Testbench for the convolution row engine.
 * Every bank is preloaded before the first job, so no read returns an unwritten word.
 * Expected results come from a mirror of all preload writes and a reference model.
 * The run stops at the first mismatch. A watchdog bounds the run time.
 */

`timescale 1ns/100ps

module conv_engine_tb
  import conv_cfg_pkg::*, conv_types_pkg::*;
;

  localparam int     N_RAND_JOBS = 40;                    // Random jobs in the main test.
  localparam longint SAT_HI      = 64'sd2147483647;       // Largest signed 32-bit value.
  localparam longint SAT_LO      = -64'sd2147483648;      // Smallest signed 32-bit value.

  logic        clk;                                       // DUT clock.
  logic        rst_n;                                     // DUT reset, active low.
  logic        req_i;                                     // Job request to the DUT.
  job_cmd_t    cmd_i;                                     // Job command to the DUT.
  logic        ack_o;                                     // Job acknowledge from the DUT.
  row_result_t res_o;                                     // Row results from the DUT.
  preload_t    wr_i;                                      // Bank preload port.

  logic [WORD_W-1:0] mirror [N_BANK][BANK_DEPTH];         // Copy of every bank word.
  integer            seed = 32'hc938e73c;                 // Seed of the random stimulus.
  int                cycle_cnt = 0;                       // Rising edges since time zero.
  int                budget = 20;                         // Allowed cycles, reset included.
  int                issued_cnt = 0;                      // Jobs raised by the host.
  int                checked_cnt = 0;                     // Jobs checked on ack.
  int                start_cycle;                         // Edge that accepted the job.
  int                exp_latency;                         // Expected accept-to-ack cycles.
  row_result_t       exp_res;                             // Expected results of the job.
  logic              ack_seen;                            // Current ack pulse already checked.

  conv_engine_top dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .req_i (req_i),
    .cmd_i (cmd_i),
    .ack_o (ack_o),
    .res_o (res_o),
    .wr_i  (wr_i)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;                                   // 8 ns period.

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Prints the reason, then the fail message, and ends the run.
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  // Bias plus the sum of weight times activation over taps and columns, saturated.
  function automatic row_result_t compute_rows(input job_cmd_t cmd,
                                               input logic [WORD_W-1:0] mem [N_BANK][BANK_DEPTH]);
    row_result_t res;
    longint      acc;
    int          bias_a;
    int          a;
    bias_a = (int'(cmd.base_addr) + int'(cmd.bias_pos)) % BANK_DEPTH;  // Word address, wrapped.
    for (int r = 0; r < N_ROW; r++) begin
      acc = longint'($signed(mem[r*N_COL][bias_a]));     // Bias sits in the column-0 bank.
      for (int t = 0; t < int'(cmd.n_taps); t++) begin
        a = (int'(cmd.base_addr) + t) % BANK_DEPTH;
        for (int c = 0; c < N_COL; c++) begin
          acc = acc + longint'($signed(mem[r*N_COL+c][a])) * longint'($signed(cmd.act[c]));
        end
      end
      if (acc > SAT_HI) begin
        res.row[r] = 32'h7fffffff;
      end else if (acc < SAT_LO) begin
        res.row[r] = 32'h80000000;
      end else begin
        res.row[r] = acc[RES_W-1:0];
      end
    end
    return res;
  endfunction

  task automatic check_result(input row_result_t got, input row_result_t exp,
                              input string what);
    for (int r = 0; r < N_ROW; r++) begin
      if (got.row[r] !== exp.row[r]) begin
        abort_run($sformatf("Error: %0t %s row %0d is %0d, expected %0d", $time, what, r,
                            $signed(got.row[r]), $signed(exp.row[r])));
      end
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("Error: %0t ack_o came %0d cycles after acceptance, expected %0d",
                          $time, got, exp));
    end
  endtask

  task automatic check_idle(input string what);
    if (ack_o !== 1'b0) begin
      abort_run($sformatf("Error: %0t ack_o is high %s", $time, what));
    end
  endtask

  task automatic check_held(input string what);
    if (ack_o !== 1'b1) begin
      abort_run($sformatf("Error: %0t ack_o dropped %s", $time, what));
    end
  endtask

  // One host write, recorded in the mirror as well.
  task automatic write_word(input int bank, input int addr, input logic [WORD_W-1:0] data);
    @(posedge clk);
    #1;
    wr_i.valid = 1'b1;
    wr_i.bank  = BANK_IDX_W'(bank);
    wr_i.addr  = ADDR_W'(addr);
    wr_i.data  = data;
    mirror[bank][addr] = data;
    budget = budget + 1;
  endtask

  task automatic end_writes();
    @(posedge clk);
    #1;
    wr_i   = '0;
    budget = budget + 1;
  endtask

  task automatic fill_banks();
    for (int b = 0; b < N_BANK; b++) begin
      for (int a = 0; a < BANK_DEPTH; a++) begin
        write_word(b, a, WORD_W'($random(seed)));
      end
    end
    end_writes();
  endtask

  task automatic make_job(output job_cmd_t cmd);
    cmd.base_addr = ADDR_W'($random(seed));
    cmd.bias_pos  = ADDR_W'($random(seed));
    cmd.n_taps    = TAP_W'(($random(seed) & 31) + 1);    // Legal range 1 to 32.
    for (int c = 0; c < N_COL; c++) begin
      cmd.act[c] = WORD_W'($random(seed));
    end
  endtask

  // Full handshake. cmd_i is scrambled right after acceptance, and req_i is held hold cycles.
  task automatic run_job(input job_cmd_t cmd, input int hold);
    @(posedge clk);
    #1;
    exp_res     = compute_rows(cmd, mirror);
    exp_latency = int'(cmd.n_taps) + 4;
    budget      = budget + int'(cmd.n_taps) + 10;
    start_cycle = cycle_cnt + 1;                          // The next edge samples req_i.
    issued_cnt  = issued_cnt + 1;
    cmd_i       = cmd;
    req_i       = 1'b1;
    @(posedge clk);
    #1;
    cmd_i = ~cmd;                                         // Must not reach the result.
    wait (checked_cnt == issued_cnt);
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_held("while req_i was still held high");
      check_result(res_o, exp_res, "held result");
    end
    @(posedge clk);
    #1;
    req_i = 1'b0;
    @(posedge clk);                                       // This edge samples req_i low.
    @(negedge clk);
    check_idle("after req_i was sampled low");
  endtask

  // Compares each new ack pulse with the values the host expects.
  initial begin
    ack_seen = 1'b0;
    forever begin
      @(negedge clk);
      if (ack_o === 1'b1 && !ack_seen) begin
        ack_seen = 1'b1;
        if (checked_cnt == issued_cnt) begin
          abort_run("ack_o went high although no job was outstanding");
        end
        check_latency(cycle_cnt - start_cycle, exp_latency);
        check_result(res_o, exp_res, "job result");
        checked_cnt = checked_cnt + 1;
      end else if (ack_o !== 1'b1) begin
        ack_seen = 1'b0;
      end
    end
  end

  // The watchdog budget grows with each write and each job issued.
  initial begin
    forever begin
      @(posedge clk);
      if (cycle_cnt > budget) begin
        abort_run("Timeout: the req/ack handshake hung and the job never completed");
      end
    end
  end

  // Host process.
  initial begin
    job_cmd_t    cmd;
    row_result_t lim;
    $timeformat(-9, 1, " ns", 0);
    rst_n = 1'b0;
    req_i = 1'b0;
    cmd_i = '0;
    wr_i  = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_idle("after reset");
    check_result(res_o, '0, "reset value of");

    fill_banks();

    // Single tap with hand-picked words and a latency of 5.
    cmd.base_addr = 6'd5;
    cmd.bias_pos  = 6'd3;
    cmd.n_taps    = 6'd1;
    for (int r = 0; r < N_ROW; r++) begin
      write_word(r*N_COL, 8, WORD_W'(100*r - 150));      // Bias at base plus bias_pos.
      for (int c = 0; c < N_COL; c++) begin
        write_word(r*N_COL+c, 5, WORD_W'((r+1) * (c+2) * ((c % 2 == 1) ? -1 : 1)));
      end
    end
    end_writes();
    for (int c = 0; c < N_COL; c++) begin
      cmd.act[c] = WORD_W'(7 - 3*c);
    end
    run_job(cmd, 0);

    // Random jobs with every fourth one forced across address 63.
    for (int j = 0; j < N_RAND_JOBS; j++) begin
      make_job(cmd);
      if (j % 4 == 0) begin
        cmd.base_addr = ADDR_W'(BANK_DEPTH - int'(cmd.n_taps) / 2);
      end
      run_job(cmd, j % 3);
    end

    // Same job again after rewriting its tap window and bias words.
    make_job(cmd);
    run_job(cmd, 0);
    for (int b = 0; b < N_BANK; b++) begin
      for (int t = 0; t < int'(cmd.n_taps); t++) begin
        write_word(b, (int'(cmd.base_addr) + t) % BANK_DEPTH, WORD_W'($random(seed)));
      end
    end
    for (int r = 0; r < N_ROW; r++) begin
      write_word(r*N_COL, (int'(cmd.base_addr) + int'(cmd.bias_pos)) % BANK_DEPTH,
                 WORD_W'($random(seed)));
    end
    end_writes();
    run_job(cmd, 1);

    // Row 0 full-scale positive, row 1 full-scale negative, 32 taps.
    for (int c = 0; c < N_COL; c++) begin
      for (int a = 0; a < BANK_DEPTH; a++) begin
        write_word(c, a, 16'h7fff);
        write_word(N_COL + c, a, 16'h8000);
      end
    end
    end_writes();
    cmd.base_addr = 6'd40;
    cmd.bias_pos  = 6'd0;
    cmd.n_taps    = 6'd32;
    for (int c = 0; c < N_COL; c++) begin
      cmd.act[c] = 16'h7fff;
    end
    run_job(cmd, 2);
    lim        = compute_rows(cmd, mirror);
    lim.row[0] = 32'h7fffffff;
    lim.row[1] = 32'h80000000;
    check_result(res_o, lim, "saturated result");

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* files.f */
common/conv_cfg_pkg.sv
common/conv_types_pkg.sv
weight_store/weight_bank.sv
weight_store/weight_loader.sv
source/job_fsm.sv
source/tap_counter.sv
source/row_accumulator.sv
source/conv_engine_top.sv
test/conv_engine_tb.sv
